// File: mmu.f
design/mmuTypes.sv
design/mmuFaults.sv
design/tableWalker.sv
design/tlb.sv
design/faultCheck.sv
design/mmu.sv
test/clockGen.sv
test/mmuTb.sv

// File: run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator, result decided from sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mmuTb -f mmu.f -o mmuSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
  echo "Verilator build failed with status $buildStatus"
  exit 1
fi

./obj_dir/mmuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Test completed successfully" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: test/mmuTb.sv
`timescale 1ns/1ps

module mmuTb;

  localparam int tlbEntries = 16;
  localparam int fixedRows  = 20;
  localparam int replRows   = tlbEntries + 2;           // Wraps the victim pointer
  localparam int numRows    = fixedRows + replRows + 2;  // Plus two revisits
  localparam int cycleLimit = numRows * 40 + 100;
  localparam logic [17:0] tBaseVal = 18'h00100;          // L1 table at 0x0040_0000
  localparam logic [31:0] l2Base   = 32'h0008_0000;      // The one coarse table

  typedef struct packed {
    logic [31:0]         addr;
    logic                write;
    logic                word;
    logic                sup;
    logic                enable;
    logic                alignCheck;
    logic                expAbort;
    mmuFaults::faultCode expCode;
    logic [19:0]         expPage;
    logic                walks;    // Miss, bus must be used
  } stimRow;

  logic                  clk;
  logic                  arstN;
  logic                  requestPa;
  mmuTypes::accessReq    req;
  mmuTypes::ctrlReg      control;
  logic [17:0]           tBase;
  logic                  hReady;
  logic [31:0]           hRData;
  logic                  hRequest;
  logic [31:0]           hAddr;
  logic                  paReady;
  logic [19:0]           physPage;
  logic                  abort;
  mmuFaults::faultStatus status;

  stimRow      rows [numRows];
  int          cycleCnt = 0;
  int          lastReadyCycle = 0; // Cycle of the latest hReady
  int          busCount = 0;       // Cycles with hRequest high
  logic [31:0] rngState;

  clockGen #(.halfPeriod(10), .resetCycles(10)) clkGen (.clk, .arstN);

  mmu #(.tlbEntries(tlbEntries)) DUT (
    .clk, .arstN, .requestPa, .req, .control, .tBase, .hReady, .hRData,
    .hRequest, .hAddr, .paReady, .physPage, .abort, .status
  );

  task automatic stopRun();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string sigName, input logic [31:0] got,
                                input logic [31:0] expected);
    $display("Mismatch at time %0t: %s is %h, expected %h", $time, sigName, got, expected);
    stopRun();
  endtask

  task automatic reportFailure(input string what);
    $display("Error at time %0t: %s", $time, what);
    stopRun();
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] sectionWord(input logic [11:0] base, input logic [1:0] ap);
    return {base, 8'h00, ap, 8'h00, 2'b10};
  endfunction

  function automatic logic [31:0] pageWord(input logic [19:0] base, input logic [1:0] ap);
    return {base, 6'h00, ap, 2'b00, 2'b10};
  endfunction

  // Unlisted table words read as fault descriptors
  function automatic logic [31:0] tableWord(input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  l2Idx;
    word  = 32'h0000_0000;
    l2Idx = addr[9:2];
    if (addr[31:14] == tBaseVal) begin
      case (addr[13:2])
        12'h001: word = sectionWord(12'h801, 2'b11); // Full access
        12'h002: word = sectionWord(12'h802, 2'b01); // Supervisor only
        12'h003: word = {l2Base[31:10], 8'h00, 2'b01}; // Coarse pointer
        12'h004: word = 32'h0000_0003;               // Reserved type
        12'h005: word = sectionWord(12'h805, 2'b00); // No access
        default: word = 32'h0000_0000;
      endcase
    end else if (addr[31:10] == l2Base[31:10]) begin
      case (l2Idx)
        8'h00:   word = pageWord(20'h90000, 2'b11);
        8'h01:   word = pageWord(20'h90001, 2'b10);   // User read-only
        8'h03:   word = {20'h90003, 6'h00, 2'b11, 2'b00, 2'b11}; // Type 11 unsupported
        8'h04:   word = pageWord(20'h90004, 2'b00);
        default: word = (l2Idx >= 8'h10) ? pageWord({12'hA00, l2Idx}, 2'b11) : 32'h0;
      endcase
    end
    return word;
  endfunction

  function automatic stimRow makeRow(input logic [31:0] addr, input logic [4:0] flags,
                                     input logic expAbort, input mmuFaults::faultCode expCode,
                                     input logic [19:0] expPage, input logic walks);
    stimRow r;
    r.addr = addr;
    {r.write, r.word, r.sup, r.enable, r.alignCheck} = flags;
    r.expAbort = expAbort;
    r.expCode  = expCode;
    r.expPage  = expPage;
    r.walks    = walks;
    return r;
  endfunction

  task automatic buildTable();
    logic [7:0] idx;
    // addr, {write word sup enable alignCheck}, abort, code, page, walks
    rows[0]  = makeRow(32'h1234_5678, 5'b10000, 1'b0, mmuFaults::NOFAULT, 20'h12345, 1'b0);
    rows[1]  = makeRow(32'h0013_4000, 5'b00010, 1'b0, mmuFaults::NOFAULT, 20'h80134, 1'b1);
    rows[2]  = makeRow(32'h0013_4000, 5'b00010, 1'b0, mmuFaults::NOFAULT, 20'h80134, 1'b0);
    rows[3]  = makeRow(32'h0015_6004, 5'b11010, 1'b0, mmuFaults::NOFAULT, 20'h80156, 1'b0);
    rows[4]  = makeRow(32'h0020_1000, 5'b00010, 1'b1, mmuFaults::PSFAULT, 20'h0, 1'b1);
    rows[5]  = makeRow(32'h0020_2000, 5'b10110, 1'b0, mmuFaults::NOFAULT, 20'h80202, 1'b0);
    rows[6]  = makeRow(32'h0030_0010, 5'b10010, 1'b0, mmuFaults::NOFAULT, 20'h90000, 1'b1);
    rows[7]  = makeRow(32'h0030_0010, 5'b10010, 1'b0, mmuFaults::NOFAULT, 20'h90000, 1'b0);
    rows[8]  = makeRow(32'h0030_1000, 5'b01010, 1'b0, mmuFaults::NOFAULT, 20'h90001, 1'b1);
    rows[9]  = makeRow(32'h0030_1004, 5'b11010, 1'b1, mmuFaults::PPFAULT, 20'h0, 1'b0);
    rows[10] = makeRow(32'h0030_1008, 5'b10110, 1'b0, mmuFaults::NOFAULT, 20'h90001, 1'b0);
    rows[11] = makeRow(32'h0030_2000, 5'b00010, 1'b1, mmuFaults::TPFAULT, 20'h0, 1'b1);
    rows[12] = makeRow(32'h0030_3000, 5'b00110, 1'b1, mmuFaults::TPFAULT, 20'h0, 1'b1);
    rows[13] = makeRow(32'h0030_4000, 5'b00110, 1'b1, mmuFaults::PPFAULT, 20'h0, 1'b1);
    rows[14] = makeRow(32'h0F00_0000, 5'b00110, 1'b1, mmuFaults::TSFAULT, 20'h0, 1'b1);
    rows[15] = makeRow(32'h0040_0000, 5'b00010, 1'b1, mmuFaults::TSFAULT, 20'h0, 1'b1);
    rows[16] = makeRow(32'h0050_0000, 5'b00110, 1'b1, mmuFaults::PSFAULT, 20'h0, 1'b1);
    rows[17] = makeRow(32'h0F10_0002, 5'b01011, 1'b1, mmuFaults::ALIGNFAULT, 20'h0, 1'b0);
    rows[18] = makeRow(32'h0013_4001, 5'b01010, 1'b0, mmuFaults::NOFAULT, 20'h80134, 1'b0);
    rows[19] = makeRow(32'h0030_0003, 5'b00011, 1'b0, mmuFaults::NOFAULT, 20'h90000, 1'b0);
    for (int i = 0; i < replRows; i++) begin
      idx = 8'h10 + 8'(i);
      rows[fixedRows + i] = makeRow({12'h003, idx, 12'h000}, 5'b00010, 1'b0,
                                    mmuFaults::NOFAULT, {12'hA00, idx}, 1'b1);
    end
    // First page overwritten by now while the last stays resident
    rows[numRows - 2] = makeRow(32'h0031_0000, 5'b00010, 1'b0, mmuFaults::NOFAULT,
                                20'hA0010, 1'b1);
    rows[numRows - 1] = rows[numRows - 3];
    rows[numRows - 1].walks = 1'b0;
  endtask

  always @(posedge clk) begin
    cycleCnt++;
    if (cycleCnt > cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      stopRun();
    end
  end

  always @(negedge clk) begin
    if (hRequest) busCount++;
    if (hReady) lastReadyCycle = cycleCnt;
  end

  // Page-table memory answering in 1 to 4 cycles
  initial begin : busModel
    int          waitLeft;
    logic [31:0] reqAddr;
    hReady   = 1'b0;
    hRData   = '0;
    rngState = 32'hd372;
    waitLeft = -1;
    reqAddr  = '0;
    forever begin
      @(posedge clk);
      #2;
      hReady = 1'b0;
      assert (hRequest || waitLeft < 0) else reportFailure("hRequest dropped before hReady");
      if (hRequest) begin
        if (waitLeft < 0) begin
          rngState = xorshift32(rngState);
          waitLeft = 1 + int'(rngState % 32'd4);
          reqAddr  = hAddr;
        end
        assert (hAddr == reqAddr) else reportMismatch("hAddr", hAddr, reqAddr);
        waitLeft--;
        if (waitLeft == 0) begin
          hReady   = 1'b1;
          hRData   = tableWord(hAddr);
          waitLeft = -1;
        end
      end
    end
  end

  initial begin : mainSeq
    int reqCycle;
    int busBefore;
    requestPa = 1'b0;
    req       = '0;
    control   = '0;
    tBase     = tBaseVal;
    buildTable();
    @(posedge arstN);
    @(negedge clk);
    assert (!paReady && !abort && !hRequest) else reportFailure("outputs active after reset");
    for (int i = 0; i < numRows; i++) begin
      @(posedge clk);
      #2;
      req.va             = rows[i].addr;
      req.write          = rows[i].write;
      req.word           = rows[i].word;
      req.supervisor     = rows[i].sup;
      control.enable     = rows[i].enable;
      control.alignCheck = rows[i].alignCheck;
      requestPa          = 1'b1; // One-cycle strobe
      reqCycle           = cycleCnt;
      busBefore          = busCount;
      @(negedge clk);
      while (!paReady) begin
        @(posedge clk);
        #2;
        requestPa = 1'b0;
        @(negedge clk);
      end
      assert (abort == rows[i].expAbort)
        else reportMismatch("abort", 32'(abort), 32'(rows[i].expAbort));
      assert (status.code == rows[i].expCode)
        else reportMismatch("status.code", 32'(status.code), 32'(rows[i].expCode));
      if (rows[i].expAbort) begin
        assert (status.faultAddr == rows[i].addr)
          else reportMismatch("status.faultAddr", status.faultAddr, rows[i].addr);
      end else begin
        assert (physPage == rows[i].expPage)
          else reportMismatch("physPage", 32'(physPage), 32'(rows[i].expPage));
      end
      if (rows[i].walks) begin
        assert (busCount != busBefore) else reportFailure("expected table walk never used the bus");
        assert (cycleCnt - lastReadyCycle == 2)
          else reportMismatch("paReady delay after hReady", 32'(cycleCnt - lastReadyCycle), 32'd2);
      end else begin
        assert (busCount == busBefore) else reportFailure("bus request on a hit or early fault");
        assert (cycleCnt - reqCycle == 2)
          else reportMismatch("paReady latency", 32'(cycleCnt - reqCycle), 32'd2);
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int halfPeriod  = 10, // 20 ns period
  parameter int resetCycles = 10
) (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #(halfPeriod) clk = ~clk;
  end

  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #2 arstN = 1'b1; // Released just after an edge
  end

endmodule

// File: design/mmu.sv
`timescale 1ns/1ps

module mmu #(
  parameter int tlbEntries = 16
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  requestPa,
  input  mmuTypes::accessReq    req,
  input  mmuTypes::ctrlReg      control,
  input  logic [17:0]           tBase,
  input  logic                  hReady,
  input  logic [31:0]           hRData,
  output logic                  hRequest,
  output logic [31:0]           hAddr,
  output logic                  paReady,
  output logic [19:0]           physPage,
  output logic                  abort,
  output mmuFaults::faultStatus status
);

  typedef enum logic [1:0] {idle, lookup, walking, result} ctlState;

  ctlState             state;
  logic                busy;       // Requests dropped while set
  mmuTypes::accessReq  curReq;
  mmuTypes::ctrlReg    curCtrl;    // Control sampled with the request
  logic                hit;
  mmuTypes::tlbEntry   hitEntry;
  mmuTypes::tlbEntry   fillEntry;
  mmuTypes::tlbEntry   finalEntry;
  logic                fillValid;
  logic                walkFault;
  mmuFaults::faultCode walkCode;
  logic                startWalk;
  logic                evaluate;
  logic                bypass;
  logic                alignFault;

  assign busy       = (state == lookup) || (state == walking);
  assign bypass     = !curCtrl.enable;
  assign alignFault = curCtrl.alignCheck && curReq.word && (curReq.va.pageOffset[1:0] != 2'b00);
  // Walk only when nothing else settles the lookup cycle
  assign startWalk  = (state == lookup) && !bypass && !alignFault && !hit;
  assign evaluate   = ((state == lookup) && !startWalk) ||
                      ((state == walking) && (fillValid || walkFault));
  assign finalEntry = (state == walking) ? fillEntry : hitEntry;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= idle;
    end else begin
      case (state)
        idle, result: state <= requestPa ? lookup : idle; // New request right after paReady
        lookup:       state <= startWalk ? walking : result;
        walking:      if (fillValid || walkFault) state <= result;
        default:      state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (requestPa && !busy) begin
      curReq  <= req;
      curCtrl <= control;
    end
  end

  tlb #(.tlbEntries(tlbEntries)) tlbInst (
    .clk, .arstN, .lookupTag({curReq.va.l1Index, curReq.va.l2Index}),
    .hit, .hitEntry, .fillValid, .fillEntry
  );

  tableWalker walkerInst (
    .clk, .arstN, .startWalk, .vAddr(curReq.va), .tBase, .hReady, .hRData,
    .hRequest, .hAddr, .fillValid, .fillEntry, .walkFault, .walkCode
  );

  faultCheck checkInst (
    .clk, .arstN, .evaluate, .req(curReq), .entry(finalEntry), .bypass, .alignFault,
    .walkFault, .walkCode, .paReady, .physPage, .abort, .status
  );

endmodule

// File: design/faultCheck.sv
`timescale 1ns/1ps

module faultCheck (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  evaluate,   // Result due next cycle
  input  mmuTypes::accessReq    req,
  input  mmuTypes::tlbEntry     entry,      // Hit or fresh fill
  input  logic                  bypass,     // Translation off
  input  logic                  alignFault,
  input  logic                  walkFault,
  input  mmuFaults::faultCode   walkCode,
  output logic                  paReady,
  output logic [19:0]           physPage,
  output logic                  abort,
  output mmuFaults::faultStatus status
);

  logic                permOk;
  logic [19:0]         pageOut;
  mmuFaults::faultCode code;

  // AP decode
  always_comb begin
    case (entry.ap)
      2'b00:   permOk = 1'b0;                          // No access
      2'b01:   permOk = req.supervisor;                // Supervisor only
      2'b10:   permOk = req.supervisor || !req.write;  // User read-only
      default: permOk = 1'b1;                          // Full access
    endcase
  end

  // Priority: alignment, walk, permission
  always_comb begin
    code = mmuFaults::NOFAULT;
    if (alignFault) begin
      code = mmuFaults::ALIGNFAULT;
    end else if (bypass) begin
      code = mmuFaults::NOFAULT;
    end else if (walkFault) begin
      code = walkCode;
    end else if (!permOk) begin
      code = entry.isSection ? mmuFaults::PSFAULT : mmuFaults::PPFAULT;
    end
  end

  // Section page keeps VA bits 19:12
  always_comb begin
    if (bypass) begin
      pageOut = {req.va.l1Index, req.va.l2Index};
    end else if (entry.isSection) begin
      pageOut = {entry.pPage[19:8], req.va.l2Index};
    end else begin
      pageOut = entry.pPage;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      paReady <= 1'b0;
      abort   <= 1'b0;
    end else begin
      paReady <= evaluate; // One-cycle pulse
      abort   <= evaluate && (code != mmuFaults::NOFAULT);
    end
  end

  always_ff @(posedge clk) begin
    if (evaluate) begin
      physPage         <= pageOut;
      status.code      <= code;
      status.faultAddr <= req.va; // FAR
    end
  end

endmodule

// File: design/tlb.sv
`timescale 1ns/1ps

module tlb #(
  parameter int tlbEntries = 16
) (
  input  logic              clk,
  input  logic              arstN,
  input  logic [19:0]       lookupTag,
  output logic              hit,
  output mmuTypes::tlbEntry hitEntry,
  input  logic              fillValid,
  input  mmuTypes::tlbEntry fillEntry
);

  localparam int idxW = $clog2(tlbEntries);

  mmuTypes::tlbEntry     entries [tlbEntries];
  logic [tlbEntries-1:0] validBits; // Cleared on reset
  logic [tlbEntries-1:0] match;
  logic [idxW-1:0]       hitIdx;
  logic [idxW-1:0]       fillPtr;   // Round-robin victim

  // All slots compared at once
  always_comb begin
    for (int i = 0; i < tlbEntries; i++) begin
      if (entries[i].isSection) begin
        // Section covers 256 pages
        match[i] = validBits[i] && (entries[i].vTag[19:8] == lookupTag[19:8]);
      end else begin
        match[i] = validBits[i] && (entries[i].vTag == lookupTag);
      end
    end
  end

  // Lowest matching slot wins
  always_comb begin
    hitIdx = '0;
    for (int i = tlbEntries - 1; i >= 0; i--) begin
      if (match[i]) begin
        hitIdx = idxW'(i);
      end
    end
  end

  assign hit = |match;

  always_comb begin
    hitEntry       = entries[hitIdx];
    hitEntry.valid = hit; // Stored valid bit lives in validBits
  end

  // Valid bits and replacement pointer
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      validBits <= '0;
      fillPtr   <= '0;
    end else if (fillValid) begin
      validBits[fillPtr] <= fillEntry.valid;
      fillPtr            <= fillPtr + 1'b1; // Wraps, size is a power of two
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (fillValid) begin
      entries[fillPtr] <= fillEntry;
    end
  end

endmodule

// File: design/tableWalker.sv
`timescale 1ns/1ps

module tableWalker (
  input  logic                clk,
  input  logic                arstN,
  input  logic                startWalk,
  input  mmuTypes::virtAddr   vAddr,
  input  logic [17:0]         tBase,
  input  logic                hReady,
  input  logic [31:0]         hRData,
  output logic                hRequest,
  output logic [31:0]         hAddr,
  output logic                fillValid,
  output mmuTypes::tlbEntry   fillEntry,
  output logic                walkFault,
  output mmuFaults::faultCode walkCode
);

  typedef enum logic [1:0] {
    idle,
    l1Read,
    l2Read,
    done
  } walkState;

  walkState          state;
  mmuTypes::l1Desc   l1Word;  // Section or coarse view
  mmuTypes::pageDesc l2Word;
  mmuTypes::tlbEntry l1Entry; // Section entry built from l1Word
  mmuTypes::tlbEntry l2Entry; // Small page entry built from l2Word
  logic              l1Ack;
  logic              l2Ack;
  logic              l1Ok;    // Section found
  logic              l2Ok;    // Small page found
  logic              toL2;    // Coarse pointer, go one level down

  assign l1Word = hRData;
  assign l2Word = hRData;

  // Bus beat completes only while we are asking
  assign l1Ack = (state == l1Read) && hRequest && hReady;
  assign l2Ack = (state == l2Read) && hRequest && hReady;

  // Type bits sit in the same place in both views
  assign l1Ok = l1Word.section.dType == mmuTypes::SECTIONDESC;
  assign toL2 = l1Word.coarse.dType == mmuTypes::COARSEDESC;
  assign l2Ok = l2Word.dType == mmuTypes::SECTIONDESC; // Small page is 10 too

  always_comb begin
    l1Entry.valid     = 1'b1;
    l1Entry.isSection = 1'b1;
    l1Entry.vTag      = {vAddr.l1Index, vAddr.l2Index};
    l1Entry.pPage     = {l1Word.section.base, 8'h00}; // Low bits from VA later
    l1Entry.ap        = l1Word.section.ap;

    l2Entry.valid     = 1'b1;
    l2Entry.isSection = 1'b0;
    l2Entry.vTag      = {vAddr.l1Index, vAddr.l2Index};
    l2Entry.pPage     = l2Word.base;
    l2Entry.ap        = l2Word.ap;
  end

  // Control FSM
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state     <= idle;
      hRequest  <= 1'b0;
      fillValid <= 1'b0;
      walkFault <= 1'b0;
    end else begin
      fillValid <= 1'b0; // Pulses
      walkFault <= 1'b0;
      case (state)
        idle: begin
          if (startWalk) begin
            state    <= l1Read;
            hRequest <= 1'b1;
          end
        end
        l1Read: begin
          if (l1Ack) begin
            hRequest <= 1'b0; // Drop for one cycle at least
            if (toL2) begin
              state <= l2Read;
            end else begin
              state     <= done;
              fillValid <= l1Ok;
              walkFault <= !l1Ok; // Fault or reserved
            end
          end
        end
        l2Read: begin
          if (l2Ack) begin
            hRequest  <= 1'b0;
            state     <= done;
            fillValid <= l2Ok;
            walkFault <= !l2Ok;   // Large and tiny count as faults
          end else begin
            hRequest <= 1'b1;     // Re-raise after the gap
          end
        end
        done: state <= idle; // Result pulse cycle
        default: state <= idle;
      endcase
    end
  end

  // Bus address and result payload
  always_ff @(posedge clk) begin
    if ((state == idle) && startWalk) begin
      hAddr <= {tBase, vAddr.l1Index, 2'b00}; // TTB | L1 index
    end
    if (l1Ack) begin
      hAddr     <= {l1Word.coarse.tableBase, vAddr.l2Index, 2'b00};
      fillEntry <= l1Entry;
      walkCode  <= mmuFaults::TSFAULT;
    end
    if (l2Ack) begin
      fillEntry <= l2Entry;
      walkCode  <= mmuFaults::TPFAULT;
    end
  end

endmodule

// File: design/mmuFaults.sv
package mmuFaults;

  // FSR status encodings, listed in priority order
  typedef enum logic [3:0] {
    VECTORFAULT = 4'b0000,
    ALIGNFAULT  = 4'b0001, // Any 00x1 reads as alignment
    TSFAULT     = 4'b0101, // Translation, section
    TPFAULT     = 4'b0111, // Translation, page
    PSFAULT     = 4'b1101, // Permission, section
    PPFAULT     = 4'b1111, // Permission, page
    NOFAULT     = 4'b1000  // External abort code, free here
  } faultCode;

  // What the core sees on an abort
  typedef struct packed {
    faultCode    code;
    logic [31:0] faultAddr; // Virtual address of the failing access
  } faultStatus;

endpackage

// File: design/mmuTypes.sv
package mmuTypes;

  // Virtual address split for a two-level walk
  typedef struct packed {
    logic [11:0] l1Index;    // First-level table index
    logic [7:0]  l2Index;    // Coarse table index
    logic [11:0] pageOffset;
  } virtAddr;

  // One translation request from the core
  typedef struct packed {
    virtAddr va;
    logic    write;      // Store access
    logic    word;       // Word-sized access, alignment relevant
    logic    supervisor; // Privileged mode
  } accessReq;

  typedef struct packed {
    logic enable;     // Translation on
    logic alignCheck; // Alignment faults on
  } ctrlReg;

  // Low two bits of every descriptor
  typedef enum logic [1:0] {
    FAULTDESC    = 2'b00,
    COARSEDESC   = 2'b01,
    SECTIONDESC  = 2'b10, // Also small page at second level
    RESERVEDDESC = 2'b11
  } descType;

  typedef struct packed {
    logic [11:0] base;   // 1 MB section base
    logic [7:0]  sbz;
    logic [1:0]  ap;
    logic [7:0]  unused; // Domain and cache bits not modeled
    descType     dType;
  } sectionDesc;

  typedef struct packed {
    logic [21:0] tableBase; // Coarse table, 1 KB aligned
    logic [7:0]  unused;
    descType     dType;
  } coarseDesc;

  // Same fetched word, two readings
  typedef union packed {
    sectionDesc section;
    coarseDesc  coarse;
  } l1Desc;

  typedef struct packed {
    logic [19:0] base;   // 4 KB page base
    logic [5:0]  unused;
    logic [1:0]  ap;     // Single AP for the whole page
    logic [1:0]  cb;
    descType     dType;
  } pageDesc;

  typedef struct packed {
    logic        valid;
    logic        isSection; // Match on top 12 tag bits only
    logic [19:0] vTag;
    logic [19:0] pPage;
    logic [1:0]  ap;
  } tlbEntry;

endpackage
